// ==== include/mem_monitor_params.svh ====
`ifndef MEM_MONITOR_PARAMS_SVH
`define MEM_MONITOR_PARAMS_SVH

// ################################################
// memory geometry
// ################################################
`define MM_WIDTH     32    // data bits per word
`define MM_BITADDR   13
`define MM_NUMADDR   6144  // top quarter of the 13-bit space is illegal
`define MM_BITWDTH   5     // bit select into a word

// ################################################
// ports and timing
// ################################################
`define MM_NUMWRPT   4
`define MM_NUMRDPT   2
`define MM_RD_DELAY  2     // read strobe to response
`define MM_CNT_W     8     // saturating error counter

`endif

// ==== logic/mem_monitor_pkg.sv ====
`include "mem_monitor_params.svh"

package mem_monitor_pkg;

  // ################################################
  // request and response ports
  // ################################################
  typedef struct packed {
    logic                    vld;
    logic [`MM_BITADDR-1:0]  addr;
    logic [`MM_WIDTH-1:0]    data;
  } wr_req_t;

  typedef struct packed {
    logic                    vld;
    logic [`MM_BITADDR-1:0]  addr;
  } rd_req_t;

  typedef struct packed {
    logic                    vld;
    logic [`MM_WIDTH-1:0]    dout;  // full word but only the select bit is checked
  } rd_rsp_t;

  // ################################################
  // violations and status
  // ################################################
  typedef struct packed {
    logic [`MM_NUMWRPT-1:0]  wr_range;
    logic [`MM_NUMRDPT-1:0]  rd_range;
    logic                    wr_dup;
  } access_viol_t;

  typedef struct packed {
    logic [`MM_NUMRDPT-1:0]  rd_data;
    logic [`MM_NUMRDPT-1:0]  rd_vld;   // response valid missing
  } data_viol_t;

  // order of the codes is also the priority order
  typedef enum logic [2:0] {
    ERR_NONE     = 3'd0,
    ERR_WR_RANGE = 3'd1,
    ERR_RD_RANGE = 3'd2,
    ERR_WR_DUP   = 3'd3,
    ERR_RD_DATA  = 3'd4,
    ERR_RD_VLD   = 3'd5
  } err_code_e;

  typedef struct packed {
    logic       wr_range;
    logic       rd_range;
    logic       wr_dup;
    logic       rd_data;
    logic       rd_vld;
    err_code_e  first_code;
  } err_status_t;

endpackage

// ==== logic/access_range_check.sv ====
`timescale 1ns/1ps
`include "mem_monitor_params.svh"

module access_range_check (
  input  mem_monitor_pkg::wr_req_t [`MM_NUMWRPT-1:0] wr,
  input  mem_monitor_pkg::rd_req_t [`MM_NUMRDPT-1:0] rd,
  output mem_monitor_pkg::access_viol_t              viol
);

  // ################################################
  // write port range and same-address pairs
  // ################################################
  always_comb begin
    viol.wr_range = '0;
    viol.wr_dup   = 1'b0;
    for (int i = 0; i < `MM_NUMWRPT; i++) begin
      viol.wr_range[i] = wr[i].vld && (wr[i].addr >= `MM_NUMADDR);
      // each unordered pair once
      for (int j = i + 1; j < `MM_NUMWRPT; j++) begin
        if (wr[i].vld && wr[j].vld && (wr[i].addr == wr[j].addr)) begin
          viol.wr_dup = 1'b1;
        end
      end
    end
  end

  // ################################################
  // read port range only
  // ################################################
  always_comb begin
    viol.rd_range = '0;
    for (int i = 0; i < `MM_NUMRDPT; i++) begin
      viol.rd_range[i] = rd[i].vld && (rd[i].addr >= `MM_NUMADDR);
    end
  end

endmodule

// ==== logic/shadow_bit_check.sv ====
`timescale 1ns/1ps
`include "mem_monitor_params.svh"

module shadow_bit_check (
  input  logic                                       clk,
  input  logic                                       rst,
  input  mem_monitor_pkg::wr_req_t [`MM_NUMWRPT-1:0] wr,
  input  mem_monitor_pkg::rd_req_t [`MM_NUMRDPT-1:0] rd,
  input  mem_monitor_pkg::rd_rsp_t [`MM_NUMRDPT-1:0] rsp,
  input  logic [`MM_BITADDR-1:0]                     select_addr,
  input  logic [`MM_BITWDTH-1:0]                     select_bit,
  output mem_monitor_pkg::data_viol_t                viol
);

  logic                    shadow_vld;
  logic                    shadow_val;
  logic [`MM_RD_DELAY-1:0] issued_q  [`MM_NUMRDPT];
  logic [`MM_RD_DELAY-1:0] checked_q [`MM_NUMRDPT];
  logic [`MM_RD_DELAY-1:0] expect_q  [`MM_NUMRDPT];

  // ################################################
  // shadow of the selected bit
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_vld <= 1'b0;
    end else begin
      for (int p = 0; p < `MM_NUMWRPT; p++) begin
        if (wr[p].vld && (wr[p].addr == select_addr)) begin
          shadow_vld <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MM_NUMWRPT; p++) begin
      if (wr[p].vld && (wr[p].addr == select_addr)) begin
        shadow_val <= wr[p].data[select_bit];  // later port overrides
      end
    end
  end

  // ################################################
  // per-port shift lines with one entry per cycle
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        issued_q[p]  <= '0;
        checked_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        for (int s = `MM_RD_DELAY - 1; s > 0; s--) begin
          issued_q[p][s]  <= issued_q[p][s-1];
          checked_q[p][s] <= checked_q[p][s-1];
        end
        issued_q[p][0]  <= rd[p].vld;
        // same-cycle write not seen by this read
        checked_q[p][0] <= rd[p].vld && (rd[p].addr == select_addr) && shadow_vld;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      for (int s = `MM_RD_DELAY - 1; s > 0; s--) begin
        expect_q[p][s] <= expect_q[p][s-1];
      end
      expect_q[p][0] <= shadow_val;
    end
  end

  // compare at the end of the line in cycle n+MM_RD_DELAY
  always_comb begin
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      viol.rd_vld[p]  = issued_q[p][`MM_RD_DELAY-1] && !rsp[p].vld;
      viol.rd_data[p] = checked_q[p][`MM_RD_DELAY-1] && rsp[p].vld &&
                        (rsp[p].dout[select_bit] != expect_q[p][`MM_RD_DELAY-1]);
    end
  end

  a_select_addr_legal: assert property (@(posedge clk) disable iff (rst)
    select_addr < `MM_NUMADDR);

endmodule

// ==== logic/error_collect.sv ====
`timescale 1ns/1ps
`include "mem_monitor_params.svh"

module error_collect (
  input  logic                          clk,
  input  logic                          rst,
  input  mem_monitor_pkg::access_viol_t acc,
  input  mem_monitor_pkg::data_viol_t   dat,
  output mem_monitor_pkg::err_status_t  status,
  output logic [`MM_CNT_W-1:0]          err_count
);
  import mem_monitor_pkg::*;

  logic      hit_wr_range;
  logic      hit_rd_range;
  logic      hit_wr_dup;
  logic      hit_rd_data;
  logic      hit_rd_vld;
  logic      any_hit;
  err_code_e cur_code;

  // ################################################
  // reduce violations to one code per cycle
  // ################################################
  assign hit_wr_range = |acc.wr_range;
  assign hit_rd_range = |acc.rd_range;
  assign hit_wr_dup   = acc.wr_dup;
  assign hit_rd_data  = |dat.rd_data;
  assign hit_rd_vld   = |dat.rd_vld;
  assign any_hit      = hit_wr_range | hit_rd_range | hit_wr_dup | hit_rd_data | hit_rd_vld;

  always_comb begin
    if (hit_wr_range)      cur_code = ERR_WR_RANGE;
    else if (hit_rd_range) cur_code = ERR_RD_RANGE;
    else if (hit_wr_dup)   cur_code = ERR_WR_DUP;
    else if (hit_rd_data)  cur_code = ERR_RD_DATA;
    else if (hit_rd_vld)   cur_code = ERR_RD_VLD;
    else                   cur_code = ERR_NONE;
  end

  // ################################################
  // sticky status and saturating count
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      status.wr_range   <= 1'b0;
      status.rd_range   <= 1'b0;
      status.wr_dup     <= 1'b0;
      status.rd_data    <= 1'b0;
      status.rd_vld     <= 1'b0;
      status.first_code <= ERR_NONE;
      err_count         <= '0;
    end else begin
      status.wr_range <= status.wr_range | hit_wr_range;
      status.rd_range <= status.rd_range | hit_rd_range;
      status.wr_dup   <= status.wr_dup | hit_wr_dup;
      status.rd_data  <= status.rd_data | hit_rd_data;
      status.rd_vld   <= status.rd_vld | hit_rd_vld;
      if (any_hit && (status.first_code == ERR_NONE)) begin
        status.first_code <= cur_code;  // latched once
      end
      if (any_hit && (err_count != '1)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  a_first_code_hold: assert property (@(posedge clk) disable iff (rst)
    (status.first_code != ERR_NONE) |=> (status.first_code == $past(status.first_code)));

endmodule

// ==== logic/mem_monitor_top.sv ====
`timescale 1ns/1ps
`include "mem_monitor_params.svh"

module mem_monitor_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  mem_monitor_pkg::wr_req_t [`MM_NUMWRPT-1:0] wr,
  input  mem_monitor_pkg::rd_req_t [`MM_NUMRDPT-1:0] rd,
  input  mem_monitor_pkg::rd_rsp_t [`MM_NUMRDPT-1:0] rsp,
  input  logic [`MM_BITADDR-1:0]                     select_addr,
  input  logic [`MM_BITWDTH-1:0]                     select_bit,
  output mem_monitor_pkg::err_status_t               status,
  output logic [`MM_CNT_W-1:0]                       err_count
);
  import mem_monitor_pkg::*;

  access_viol_t acc_viol;  // same cycle as the request
  data_viol_t   dat_viol;  // n+MM_RD_DELAY

  // ################################################
  // legality and data checks side by side
  // ################################################
  access_range_check i_access_range_check (
    .wr   (wr),
    .rd   (rd),
    .viol (acc_viol)
  );

  shadow_bit_check i_shadow_bit_check (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .rd          (rd),
    .rsp         (rsp),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .viol        (dat_viol)
  );

  error_collect i_error_collect (
    .clk       (clk),
    .rst       (rst),
    .acc       (acc_viol),
    .dat       (dat_viol),
    .status    (status),
    .err_count (err_count)
  );

endmodule

// ==== include/tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// add_case columns are wr_vld, wr_addr p0..p3, rd_vld, rd_addr p0..p1, select_addr, select_bit,
// corrupt, drop, flags {wr_range rd_range wr_dup rd_data rd_vld}, first_code, count
// a read is answered MM_RD_DELAY rows later and its data flags show up in that row

task automatic load_cases();
  int base;
  int cnt;
  int cnt_max;
  begin
    // ################################################
    // legal traffic with the shadow invalid at first
    // ################################################
    add_case(4'h0, 0, 0, 0, 0, 2'h1, 16, 0, 16, 5, 2'h1, 2'h0, 5'h00, ERR_NONE, 0);  // no shadow
    add_case(4'h3, 16, 32, 0, 0, 2'h2, 0, 32, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h3, 16, 16, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h4, 0, 0, 16, 0, 2'h1, 16, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);  // older value
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);

    // ################################################
    // range and duplicate writes
    // ################################################
    add_case(4'h2, 0, 6144, 0, 0, 2'h1, 6200, 0, 16, 5, 2'h0, 2'h0, 5'h18, ERR_WR_RANGE, 1);
    add_case(4'h0, 0, 0, 0, 0, 2'h2, 0, 8191, 16, 5, 2'h0, 2'h0, 5'h18, ERR_WR_RANGE, 2);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h18, ERR_WR_RANGE, 2);
    add_case(4'h9, 100, 0, 0, 100, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1c, ERR_WR_RANGE, 3);
    add_case(4'he, 0, 200, 200, 300, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1c, ERR_WR_RANGE, 4);

    // ################################################
    // data and missing valid
    // ################################################
    add_case(4'h8, 0, 0, 0, 16, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1c, ERR_WR_RANGE, 4);
    add_case(4'h0, 0, 0, 0, 0, 2'h1, 16, 0, 16, 5, 2'h1, 2'h0, 5'h1c, ERR_WR_RANGE, 4);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1c, ERR_WR_RANGE, 4);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1e, ERR_WR_RANGE, 5);
    add_case(4'h0, 0, 0, 0, 0, 2'h3, 40, 16, 16, 5, 2'h0, 2'h1, 5'h1e, ERR_WR_RANGE, 5);
    add_case(4'h0, 0, 0, 0, 0, 2'h3, 41, 42, 16, 5, 2'h0, 2'h2, 5'h1e, ERR_WR_RANGE, 5);
    add_case(4'h0, 0, 0, 0, 0, 2'h3, 16, 16, 16, 5, 2'h2, 2'h0, 5'h1f, ERR_WR_RANGE, 6);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1f, ERR_WR_RANGE, 7);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1f, ERR_WR_RANGE, 8);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1f, ERR_WR_RANGE, 8);

    // ################################################
    // saturation and then reset
    // ################################################
    base    = cases[cases.size()-1].exp_count;
    cnt_max = (1 << `MM_CNT_W) - 1;
    for (int i = 1; i <= 250; i++) begin
      cnt = (base + i > cnt_max) ? cnt_max : base + i;
      add_case(4'h1, 7000, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h1f, ERR_WR_RANGE, cnt);
    end
    add_reset(RESET_CYCLES, 16, 5);
    add_case(4'h0, 0, 0, 0, 0, 2'h1, 16, 0, 16, 5, 2'h1, 2'h0, 5'h00, ERR_NONE, 0);  // invalid again
    add_case(4'h1, 16, 0, 0, 0, 2'h1, 16, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h1, 16, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
    add_case(4'h0, 0, 0, 0, 0, 2'h0, 0, 0, 16, 5, 2'h0, 2'h0, 5'h00, ERR_NONE, 0);
  end
endtask

`endif

// ==== test/tb_mem_monitor.sv ====
`timescale 1ns/1ps
`include "mem_monitor_params.svh"

module tb_mem_monitor;
  import mem_monitor_pkg::*;

  localparam int RESET_CYCLES = 4;

  typedef struct packed {
    logic                                    rst;
    logic [`MM_NUMWRPT-1:0]                  wr_vld;
    logic [`MM_NUMWRPT-1:0][`MM_BITADDR-1:0] wr_addr;
    logic [`MM_NUMRDPT-1:0]                  rd_vld;
    logic [`MM_NUMRDPT-1:0][`MM_BITADDR-1:0] rd_addr;
    logic [`MM_BITADDR-1:0]                  sel_addr;
    logic [`MM_BITWDTH-1:0]                  sel_bit;
    logic [`MM_NUMRDPT-1:0]                  corrupt;  // invert select bit in response
    logic [`MM_NUMRDPT-1:0]                  drop;     // response comes without vld
    logic [4:0]                              exp_flags;
    err_code_e                               exp_code;
    logic [`MM_CNT_W-1:0]                    exp_count;
  } tb_row_t;

  logic                              clk;
  logic                              rst;
  wr_req_t [`MM_NUMWRPT-1:0]         wr;
  rd_req_t [`MM_NUMRDPT-1:0]         rd;
  rd_rsp_t [`MM_NUMRDPT-1:0]         rsp;
  logic [`MM_BITADDR-1:0]            select_addr;
  logic [`MM_BITWDTH-1:0]            select_bit;
  err_status_t                       status;
  logic [`MM_CNT_W-1:0]              err_count;

  tb_row_t                           cases [$];
  logic [`MM_WIDTH-1:0]              mem [1 << `MM_BITADDR];
  logic                              pipe_vld  [`MM_NUMRDPT][`MM_RD_DELAY];
  logic [`MM_WIDTH-1:0]              pipe_data [`MM_NUMRDPT][`MM_RD_DELAY];
  int                                seed;
  int                                status_errs = 0;
  int                                count_errs  = 0;
  int                                cycle_cnt   = 0;
  int                                cycle_limit = 0;

  mem_monitor_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .rd          (rd),
    .rsp         (rsp),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .status      (status),
    .err_count   (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ################################################
  // table building
  // ################################################
  task automatic add_case(
    input logic [`MM_NUMWRPT-1:0] wv, input int w0, input int w1, input int w2, input int w3,
    input logic [`MM_NUMRDPT-1:0] rv, input int r0, input int r1, input int sa, input int sb,
    input logic [`MM_NUMRDPT-1:0] cor, input logic [`MM_NUMRDPT-1:0] drp,
    input logic [4:0] flags, input err_code_e code, input int cnt);
    tb_row_t row;
    begin
      row            = '0;
      row.wr_vld     = wv;
      row.wr_addr[0] = w0[`MM_BITADDR-1:0];
      row.wr_addr[1] = w1[`MM_BITADDR-1:0];
      row.wr_addr[2] = w2[`MM_BITADDR-1:0];
      row.wr_addr[3] = w3[`MM_BITADDR-1:0];
      row.rd_vld     = rv;
      row.rd_addr[0] = r0[`MM_BITADDR-1:0];
      row.rd_addr[1] = r1[`MM_BITADDR-1:0];
      row.sel_addr   = sa[`MM_BITADDR-1:0];
      row.sel_bit    = sb[`MM_BITWDTH-1:0];
      row.corrupt    = cor;
      row.drop       = drp;
      row.exp_flags  = flags;
      row.exp_code   = code;
      row.exp_count  = cnt[`MM_CNT_W-1:0];
      cases.push_back(row);
    end
  endtask

  task automatic add_reset(input int n, input int sa, input int sb);
    tb_row_t row;
    begin
      row          = '0;
      row.rst      = 1'b1;
      row.sel_addr = sa[`MM_BITADDR-1:0];
      row.sel_bit  = sb[`MM_BITWDTH-1:0];
      row.exp_code = ERR_NONE;
      for (int i = 0; i < n; i++) begin
        cases.push_back(row);
      end
    end
  endtask

  `include "tb_cases.svh"

  // ################################################
  // stimulus and memory model
  // ################################################
  task automatic drive_row(input tb_row_t row);
    logic [`MM_WIDTH-1:0] word;
    logic [`MM_WIDTH-1:0] wdata [`MM_NUMWRPT];
    begin
      rst         = row.rst;
      select_addr = row.sel_addr;
      select_bit  = row.sel_bit;
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        rsp[p].vld  = pipe_vld[p][`MM_RD_DELAY-1];
        rsp[p].dout = pipe_data[p][`MM_RD_DELAY-1];
        for (int s = `MM_RD_DELAY - 1; s > 0; s--) begin
          pipe_vld[p][s]  = pipe_vld[p][s-1];
          pipe_data[p][s] = pipe_data[p][s-1];
        end
        word = mem[row.rd_addr[p]];  // before this row's writes
        if (row.corrupt[p]) begin
          word[row.sel_bit] = ~word[row.sel_bit];
        end
        pipe_vld[p][0]  = row.rd_vld[p] && !row.drop[p];
        pipe_data[p][0] = row.rd_vld[p] ? word : '0;
        rd[p].vld       = row.rd_vld[p];
        rd[p].addr      = row.rd_addr[p];
      end
      for (int p = 0; p < `MM_NUMWRPT; p++) begin
        wdata[p] = $random(seed);
        wdata[p][row.sel_bit] = ~mem[row.wr_addr[p]][row.sel_bit];  // selected bit always flips
        wr[p].vld  = row.wr_vld[p];
        wr[p].addr = row.wr_addr[p];
        wr[p].data = wdata[p];
      end
      for (int p = 0; p < `MM_NUMWRPT; p++) begin
        if (row.wr_vld[p]) begin
          mem[row.wr_addr[p]] = wdata[p];  // higher port wins
        end
      end
    end
  endtask

  // ################################################
  // compare tasks
  // ################################################
  task automatic check_status(input err_status_t got, input err_status_t exp, input int idx);
    begin
      if (got !== exp) begin
        $display("Mismatch status row %0d: got 0x%h expected 0x%h", idx, got, exp);
        status_errs++;
      end
    end
  endtask

  task automatic check_count(input logic [`MM_CNT_W-1:0] got, input logic [`MM_CNT_W-1:0] exp,
                             input int idx);
    begin
      if (got !== exp) begin
        $display("Mismatch err_count row %0d: got 0x%h expected 0x%h", idx, got, exp);
        count_errs++;
      end
    end
  endtask

  task automatic check_row(input tb_row_t row, input int idx);
    err_status_t exp_st;
    begin
      exp_st = {row.exp_flags, row.exp_code};  // flag order matches err_status_t
      check_status(status, exp_st, idx);
      check_count(err_count, row.exp_count, idx);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing the table", cycle_limit);
      $display("errors: %0d status, %0d count", status_errs, count_errs);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    seed        = 32'hf1cf_2234;
    rst         = 1'b1;
    wr          = '0;
    rd          = '0;
    rsp         = '0;
    select_addr = 13'd16;
    select_bit  = 5'd5;
    for (int a = 0; a < (1 << `MM_BITADDR); a++) begin
      mem[a] = $random(seed) ^ a;
    end
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      for (int s = 0; s < `MM_RD_DELAY; s++) begin
        pipe_vld[p][s]  = 1'b0;
        pipe_data[p][s] = '0;
      end
    end
    load_cases();
    cycle_limit = cases.size() + RESET_CYCLES + `MM_RD_DELAY + 16;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    for (int i = 0; i < cases.size(); i++) begin
      drive_row(cases[i]);
      @(negedge clk);  // result of the row is registered by now
      check_row(cases[i], i);
    end
    $display("errors: %0d status, %0d count", status_errs, count_errs);
    if (status_errs + count_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
logic/mem_monitor_pkg.sv
logic/access_range_check.sv
logic/shadow_bit_check.sv
logic/error_collect.sv
logic/mem_monitor_top.sv
test/tb_mem_monitor.sv

// ==== Makefile ====
# Verilator build and run for the memory monitor testbench.
# Any variable below can be overridden, e.g. make run BUILD_DIR=obj

VERILATOR ?= verilator
SIM_TOP   ?= tb_mem_monitor
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)
SOURCES := $(wildcard logic/*.sv test/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(SIM_TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
